// File: rtl/exu_pkg.sv
package exu_pkg;

    // the shift logic is written for a 64-bit data path
    localparam int XLEN  = 64;

    // physical register tag
    localparam int IPR_W = 6;
    localparam int ROB_W = 6;
    localparam int FTQ_W = 4;

    // byte offset of an instruction inside its fetch block
    localparam int OFS_W = 5;

    // alu group first, then auipc, then the branch group
    // anything ordered after uop_auipc is branch-class
    typedef enum logic [4:0] {
        uop_lui,  uop_add,  uop_sub,  uop_addw,
        uop_subw, uop_sll,  uop_srl,  uop_sra,
        uop_sllw, uop_srlw, uop_sraw, uop_xor,
        uop_or,   uop_and,  uop_slt,  uop_sltu,
        uop_auipc,
        uop_jal,  uop_jalr, uop_beq,  uop_bne,
        uop_blt,  uop_bge,  uop_bltu, uop_bgeu
    } micop_t;

    // class reported to the branch predictor
    typedef enum logic [2:0] {
        br_cond,
        br_direct,
        br_indirect,
        br_call,
        br_ret
    } branch_type_t;

    typedef struct packed {
        micop_t                      micop;
        logic [XLEN-1:0]             pc;
        // predicted next pc from the frontend
        logic [XLEN-1:0]             npc;
        logic [19:0]                 imm20;
        logic [1:0][XLEN-1:0]        srcs;
        logic [1:0][IPR_W-1:0]       iprs_idx;
        // src 1 carries the immediate
        logic                        use_imm;
        logic [IPR_W-1:0]            iprd_idx;
        logic                        rd_wen;
        logic [ROB_W-1:0]            rob_idx;
        logic [FTQ_W-1:0]            ftq_idx;
        logic [OFS_W-1:0]            ftq_offset;
    } fu_info_t;

    typedef struct packed {
        logic [ROB_W-1:0]            rob_idx;
        logic [IPR_W-1:0]            iprd_idx;
        logic                        rd_wen;
        logic [XLEN-1:0]             result;
    } comwb_info_t;

    typedef struct packed {
        branch_type_t                branch_type;
        logic [ROB_W-1:0]            rob_idx;
        logic [FTQ_W-1:0]            ftq_idx;
        logic                        has_mispred;
        logic                        taken;
        logic [OFS_W-1:0]            fallthru_offset;
        logic [XLEN-1:0]             target_pc;
        logic [XLEN-1:0]             branch_npc;
    } branchwb_info_t;

endpackage

// File: rtl/operand_bypass.sv
`timescale 1ns/1ps

module operand_bypass import exu_pkg::*; (
    input  logic             i_vld,
    input  fu_info_t         i_fu_info,

    // early result announced by stage one of alu_bru
    input  logic             i_willwrite_vld,
    input  logic [IPR_W-1:0] i_willwrite_rd_idx,
    input  logic [XLEN-1:0]  i_willwrite_data,

    output logic             o_vld,
    output fu_info_t         o_fu_info
);

    logic hit_src0;
    logic hit_src1;

    assign hit_src0 = i_willwrite_vld &&
                      (i_fu_info.iprs_idx[0] == i_willwrite_rd_idx);

    // src 1 holds the immediate when use_imm is set
    assign hit_src1 = i_willwrite_vld && !i_fu_info.use_imm &&
                      (i_fu_info.iprs_idx[1] == i_willwrite_rd_idx);

    always_comb begin
        o_fu_info = i_fu_info;
        if (hit_src0) begin
            o_fu_info.srcs[0] = i_willwrite_data;
        end
        if (hit_src1) begin
            o_fu_info.srcs[1] = i_willwrite_data;
        end
    end

    assign o_vld = i_vld;

endmodule

// File: rtl/alu_bru.sv
`timescale 1ns/1ps

module alu_bru import exu_pkg::*; (
    input  logic             clk,
    input  logic             rst,

    input  logic             i_vld,
    input  fu_info_t         i_fu_info,
    input  logic             i_wb_stall,

    // early result one cycle ahead of writeback for the operand bypass
    output logic             o_willwrite_vld,
    output logic [IPR_W-1:0] o_willwrite_rd_idx,
    output logic [XLEN-1:0]  o_willwrite_data,

    output logic             o_fu_finished,
    output comwb_info_t      o_comwb_info,
    output logic             o_branchwb_vld,
    output branchwb_info_t   o_branchwb_info
);

    logic            s1_vld;
    fu_info_t        s1_info;

    logic [XLEN-1:0] src0;
    logic [XLEN-1:0] src1;
    logic [5:0]      shamt;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic [XLEN-1:0] sll_res;
    logic [XLEN-1:0] srl_res;
    logic [XLEN-1:0] sra_res;
    logic            lt_s;
    logic            lt_u;
    logic [XLEN-1:0] alu_res;

    logic [XLEN-1:0] imm_sext;
    logic [XLEN-1:0] fallthru;
    logic [XLEN-1:0] pc_rel;
    logic [XLEN-1:0] target;
    logic [XLEN-1:0] npc;
    logic            is_auipc;
    logic            is_branch;
    logic            taken;
    logic            mispred;
    branch_type_t    br_type;

    // stage one
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_vld <= 1'b0;
        end else if (!i_wb_stall) begin
            s1_vld <= i_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_wb_stall) begin
            s1_info <= i_fu_info;
        end
    end

    assign src0  = s1_info.srcs[0];
    assign src1  = s1_info.srcs[1];
    assign shamt = src1[5:0];

    assign sum     = src0 + src1;
    assign diff    = src0 - src1;
    assign sll_res = src0 << shamt;
    assign srl_res = src0 >> shamt;
    assign sra_res = $signed(src0) >>> shamt;
    assign lt_s    = $signed(src0) < $signed(src1);
    assign lt_u    = src0 < src1;

    // word forms take the low half of the full result and sign-extend it
    always_comb begin
        case (s1_info.micop)
            uop_lui:  alu_res = {{32{src1[19]}}, src1[19:0], 12'd0};
            uop_add:  alu_res = sum;
            uop_sub:  alu_res = diff;
            uop_addw: alu_res = {{32{sum[31]}}, sum[31:0]};
            uop_subw: alu_res = {{32{diff[31]}}, diff[31:0]};
            uop_sll:  alu_res = sll_res;
            uop_srl:  alu_res = srl_res;
            uop_sra:  alu_res = sra_res;
            uop_sllw: alu_res = {{32{sll_res[31]}}, sll_res[31:0]};
            uop_srlw: alu_res = {{32{srl_res[31]}}, srl_res[31:0]};
            uop_sraw: alu_res = {{32{sra_res[31]}}, sra_res[31:0]};
            uop_xor:  alu_res = src0 ^ src1;
            uop_or:   alu_res = src0 | src1;
            uop_and:  alu_res = src0 & src1;
            uop_slt:  alu_res = {{(XLEN-1){1'b0}}, lt_s};
            uop_sltu: alu_res = {{(XLEN-1){1'b0}}, lt_u};
            default:  alu_res = '0;
        endcase
    end

    // branch side
    assign is_auipc  = (s1_info.micop == uop_auipc);
    assign is_branch = (s1_info.micop > uop_auipc);

    assign imm_sext = {{(XLEN-20){s1_info.imm20[19]}}, s1_info.imm20};
    assign fallthru = s1_info.pc + 64'd4;
    assign pc_rel   = s1_info.pc + imm_sext;

    always_comb begin
        case (s1_info.micop)
            uop_jal:  taken = 1'b1;
            uop_jalr: taken = 1'b1;
            uop_beq:  taken = (src0 == src1);
            uop_bne:  taken = (src0 != src1);
            uop_blt:  taken = lt_s;
            uop_bge:  taken = !lt_s;
            uop_bltu: taken = lt_u;
            uop_bgeu: taken = !lt_u;
            default:  taken = 1'b0;
        endcase
    end

    assign target  = (s1_info.micop == uop_jalr) ? (src0 + imm_sext) : pc_rel;
    assign npc     = taken ? target : fallthru;
    assign mispred = is_branch && (npc != s1_info.npc);

    // tag 1 and tag 0 are the fixed mappings of ra and x0 at rename
    always_comb begin
        if (s1_info.micop == uop_jalr && s1_info.iprd_idx == IPR_W'(1)) begin
            br_type = br_call;
        end else if (s1_info.micop == uop_jalr && s1_info.iprd_idx == IPR_W'(0)) begin
            br_type = br_ret;
        end else if (s1_info.micop == uop_jalr) begin
            br_type = br_indirect;
        end else if (s1_info.micop == uop_jal) begin
            br_type = br_direct;
        end else begin
            br_type = br_cond;
        end
    end

    assign o_willwrite_vld    = s1_vld && s1_info.rd_wen;
    assign o_willwrite_rd_idx = s1_info.iprd_idx;
    assign o_willwrite_data   = is_branch ? fallthru :
                                is_auipc  ? pc_rel   : alu_res;

    // stage two holds the writeback records
    always_ff @(posedge clk) begin
        if (rst) begin
            o_fu_finished  <= 1'b0;
            o_branchwb_vld <= 1'b0;
        end else if (!i_wb_stall) begin
            o_fu_finished  <= s1_vld;
            // only a mispredict is reported to the frontend
            o_branchwb_vld <= s1_vld && mispred;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_wb_stall) begin
            o_comwb_info.rob_idx  <= s1_info.rob_idx;
            o_comwb_info.iprd_idx <= s1_info.iprd_idx;
            o_comwb_info.rd_wen   <= s1_info.rd_wen;
            o_comwb_info.result   <= o_willwrite_data;

            o_branchwb_info.branch_type     <= br_type;
            o_branchwb_info.rob_idx         <= s1_info.rob_idx;
            o_branchwb_info.ftq_idx         <= s1_info.ftq_idx;
            o_branchwb_info.has_mispred     <= mispred;
            o_branchwb_info.taken           <= taken;
            o_branchwb_info.fallthru_offset <= s1_info.ftq_offset + OFS_W'(4);
            o_branchwb_info.target_pc       <= target;
            o_branchwb_info.branch_npc      <= npc;
        end
    end

endmodule

// File: rtl/redirect_fsm.sv
`timescale 1ns/1ps

module redirect_fsm import exu_pkg::*; (
    input  logic            clk,
    input  logic            rst,

    input  logic            i_branchwb_vld,
    input  branchwb_info_t  i_branchwb_info,

    input  logic            i_timer_done,
    output logic            o_timer_start,

    output logic            o_redirect_vld,
    output logic [XLEN-1:0] o_redirect_pc,
    output logic            o_issue_block
);

    typedef enum logic [1:0] {
        IDLE,
        REDIRECT,
        REFILL
    } state_t;

    state_t          state;
    state_t          state_nxt;
    logic            take_mispred;
    logic [XLEN-1:0] redirect_pc;

    // wrong-path mispredicts during the block are dropped here
    assign take_mispred = (state == IDLE) && i_branchwb_vld &&
                          i_branchwb_info.has_mispred;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:     if (take_mispred) state_nxt = REDIRECT;
            REDIRECT: state_nxt = REFILL;
            REFILL:   if (i_timer_done) state_nxt = IDLE;
            default:  state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (take_mispred) begin
            redirect_pc <= i_branchwb_info.branch_npc;
        end
    end

    assign o_redirect_vld = (state == REDIRECT);
    assign o_timer_start  = (state == REDIRECT);
    assign o_redirect_pc  = redirect_pc;
    assign o_issue_block  = (state != IDLE);

endmodule

// File: rtl/penalty_timer.sv
`timescale 1ns/1ps

module penalty_timer #(
    parameter int PENALTY = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic i_start,
    output logic o_busy,
    output logic o_done
);

    localparam int CNT_W = $clog2(PENALTY + 1);

    logic [CNT_W-1:0] count;
    logic             busy;

    // a start while busy simply reloads
    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (i_start) begin
            busy  <= 1'b1;
            count <= CNT_W'(PENALTY);
        end else if (busy) begin
            if (count == CNT_W'(1)) begin
                busy <= 1'b0;
            end
            count <= count - 1'b1;
        end
    end

    assign o_busy = busy;
    assign o_done = busy && (count == CNT_W'(1));

endmodule

// File: rtl/exu_top.sv
`timescale 1ns/1ps

module exu_top import exu_pkg::*; #(
    parameter int PENALTY = 4
) (
    input  logic             clk,
    input  logic             rst,

    input  logic             i_vld,
    input  fu_info_t         i_fu_info,
    input  logic             i_wb_stall,
    output logic             o_fu_stall,

    output logic             o_willwrite_vld,
    output logic [IPR_W-1:0] o_willwrite_rd_idx,
    output logic [XLEN-1:0]  o_willwrite_data,

    output logic             o_fu_finished,
    output comwb_info_t      o_comwb_info,
    output logic             o_branchwb_vld,
    output branchwb_info_t   o_branchwb_info,

    output logic             o_redirect_vld,
    output logic [XLEN-1:0]  o_redirect_pc,
    output logic             o_issue_block
);

    logic     issue_vld;
    logic     byp_vld;
    fu_info_t byp_info;
    logic     timer_start;
    logic     timer_done;

    // new issue is held off while the frontend refills
    assign issue_vld  = i_vld && !o_issue_block;
    assign o_fu_stall = i_wb_stall;

    operand_bypass operand_bypass_inst (
        .i_vld              (issue_vld),
        .i_fu_info          (i_fu_info),
        .i_willwrite_vld    (o_willwrite_vld),
        .i_willwrite_rd_idx (o_willwrite_rd_idx),
        .i_willwrite_data   (o_willwrite_data),
        .o_vld              (byp_vld),
        .o_fu_info          (byp_info)
    );

    alu_bru alu_bru_inst (
        .clk                (clk),
        .rst                (rst),
        .i_vld              (byp_vld),
        .i_fu_info          (byp_info),
        .i_wb_stall         (i_wb_stall),
        .o_willwrite_vld    (o_willwrite_vld),
        .o_willwrite_rd_idx (o_willwrite_rd_idx),
        .o_willwrite_data   (o_willwrite_data),
        .o_fu_finished      (o_fu_finished),
        .o_comwb_info       (o_comwb_info),
        .o_branchwb_vld     (o_branchwb_vld),
        .o_branchwb_info    (o_branchwb_info)
    );

    redirect_fsm redirect_fsm_inst (
        .clk                (clk),
        .rst                (rst),
        .i_branchwb_vld     (o_branchwb_vld),
        .i_branchwb_info    (o_branchwb_info),
        .i_timer_done       (timer_done),
        .o_timer_start      (timer_start),
        .o_redirect_vld     (o_redirect_vld),
        .o_redirect_pc      (o_redirect_pc),
        .o_issue_block      (o_issue_block)
    );

    penalty_timer #(
        .PENALTY            (PENALTY)
    ) penalty_timer_inst (
        .clk                (clk),
        .rst                (rst),
        .i_start            (timer_start),
        .o_busy             (),
        .o_done             (timer_done)
    );

endmodule

// File: testbench/tb_exu_ref.svh
`ifndef TB_EXU_REF_SVH
`define TB_EXU_REF_SVH

// word forms keep bits 31:0 of the 64-bit result and sign-extend them
function automatic logic [63:0] sext_word(input logic [31:0] w);
    return {{32{w[31]}}, w};
endfunction

function automatic logic [63:0] sext_imm(input logic [19:0] imm);
    return {{44{imm[19]}}, imm};
endfunction

// shifts take the low six bits of source 1
function automatic logic [63:0] ref_alu(input micop_t op, input logic [63:0] a,
                                        input logic [63:0] b);
    logic [5:0]  sh;
    logic [63:0] shl;
    logic [63:0] shr;
    logic [63:0] sha;
    logic [63:0] t;
    sh  = b[5:0];
    shl = a << sh;
    shr = a >> sh;
    sha = $signed(a) >>> sh;
    case (op)
        uop_lui:  t = sext_word({b[19:0], 12'h000});
        uop_add:  t = a + b;
        uop_sub:  t = a - b;
        uop_addw: t = sext_word(a[31:0] + b[31:0]);
        uop_subw: t = sext_word(a[31:0] - b[31:0]);
        uop_sll:  t = shl;
        uop_srl:  t = shr;
        uop_sra:  t = sha;
        uop_sllw: t = sext_word(shl[31:0]);
        uop_srlw: t = sext_word(shr[31:0]);
        uop_sraw: t = sext_word(sha[31:0]);
        uop_xor:  t = a ^ b;
        uop_or:   t = a | b;
        uop_and:  t = a & b;
        uop_slt:  t = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        uop_sltu: t = (a < b) ? 64'd1 : 64'd0;
        default:  t = 64'd0;
    endcase
    return t;
endfunction

function automatic logic ref_taken(input micop_t op, input logic [63:0] a,
                                   input logic [63:0] b);
    case (op)
        uop_jal, uop_jalr: return 1'b1;
        uop_beq:  return a == b;
        uop_bne:  return a != b;
        uop_blt:  return $signed(a) < $signed(b);
        uop_bge:  return $signed(a) >= $signed(b);
        uop_bltu: return a < b;
        uop_bgeu: return a >= b;
        default:  return 1'b0;
    endcase
endfunction

function automatic logic [63:0] ref_target(input micop_t op, input logic [63:0] pc,
                                           input logic [63:0] a, input logic [19:0] imm);
    if (op == uop_jalr) begin
        return a + sext_imm(imm);
    end
    return pc + sext_imm(imm);
endfunction

function automatic logic [63:0] ref_npc(input micop_t op, input logic [63:0] pc,
                                        input logic [63:0] a, input logic [63:0] b,
                                        input logic [19:0] imm);
    return ref_taken(op, a, b) ? ref_target(op, pc, a, imm) : pc + 64'd4;
endfunction

// destination value, branch-class ops write the return address
function automatic logic [63:0] ref_result(input micop_t op, input logic [63:0] pc,
                                           input logic [19:0] imm, input logic [63:0] a,
                                           input logic [63:0] b);
    if (op > uop_auipc) begin
        return pc + 64'd4;
    end else if (op == uop_auipc) begin
        return pc + sext_imm(imm);
    end
    return ref_alu(op, a, b);
endfunction

// ra maps to tag 1 and x0 to tag 0
function automatic branch_type_t ref_br_type(input micop_t op, input logic [5:0] rd);
    if (op == uop_jal) begin
        return br_direct;
    end else if (op == uop_jalr) begin
        return (rd == 6'd1) ? br_call : (rd == 6'd0) ? br_ret : br_indirect;
    end
    return br_cond;
endfunction

`endif

// File: testbench/tb_exu_top.sv
`timescale 1ns/1ps

module tb_exu_top import exu_pkg::*; ();

    localparam int PENALTY = 4;
    localparam int TIMEOUT = 20;

    logic           clk;
    logic           rst;
    logic           vld;
    fu_info_t       uop;
    logic           stall;
    logic           fu_stall;
    logic           ww_vld;
    logic [5:0]     ww_rd;
    logic [63:0]    ww_data;
    logic           fu_finished;
    comwb_info_t    comwb;
    logic           br_vld;
    branchwb_info_t brwb;
    logic           redirect_vld;
    logic [63:0]    redirect_pc;
    logic           issue_block;

    int             n_checks;
    int             n_errors;
    logic [63:0]    rnd_state;

    exu_top #(
        .PENALTY            (PENALTY)
    ) exu_top_inst (
        .clk                (clk),
        .rst                (rst),
        .i_vld              (vld),
        .i_fu_info          (uop),
        .i_wb_stall         (stall),
        .o_fu_stall         (fu_stall),
        .o_willwrite_vld    (ww_vld),
        .o_willwrite_rd_idx (ww_rd),
        .o_willwrite_data   (ww_data),
        .o_fu_finished      (fu_finished),
        .o_comwb_info       (comwb),
        .o_branchwb_vld     (br_vld),
        .o_branchwb_info    (brwb),
        .o_redirect_vld     (redirect_vld),
        .o_redirect_pc      (redirect_pc),
        .o_issue_block      (issue_block)
    );

    `include "tb_exu_ref.svh"

    always #50 clk = ~clk;

    function automatic logic [63:0] next_random();
        rnd_state = rnd_state ^ (rnd_state << 13);
        rnd_state = rnd_state ^ (rnd_state >> 7);
        rnd_state = rnd_state ^ (rnd_state << 17);
        return rnd_state;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        n_errors++;
        $display("timeout at %0t ns: %s", $time, what);
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("test %-8s done, %0d errors", name, n_errors - errs_before);
    endtask

    // random aligned pc with a fall-through prediction
    function automatic fu_info_t make_uop(input micop_t op, input logic [63:0] a,
                                          input logic [63:0] b, input logic [5:0] rd);
        fu_info_t    u;
        logic [63:0] r;
        u = '0;
        u.micop = op;
        r = next_random();
        u.pc  = {r[63:2], 2'b00};
        u.npc = u.pc + 64'd4;
        r = next_random();
        u.imm20       = {r[19:2], 2'b00};
        u.rob_idx     = r[25:20];
        u.ftq_idx     = r[29:26];
        u.ftq_offset  = r[34:30];
        u.srcs[0]     = a;
        u.srcs[1]     = b;
        u.iprs_idx[0] = 6'd40;
        u.iprs_idx[1] = 6'd41;
        u.iprd_idx    = rd;
        u.rd_wen      = 1'b1;
        return u;
    endfunction

    task automatic wait_finished(inout int cycles);
        while (!fu_finished && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!fu_finished) begin
            report_timeout("no o_fu_finished after issue");
        end
    endtask

    task automatic wait_unblocked();
        int guard;
        guard = 0;
        while (issue_block && guard < TIMEOUT) begin
            @(negedge clk);
            guard++;
        end
        if (issue_block) begin
            report_timeout("o_issue_block never fell");
        end
    endtask

    // issue one micro-op and check the early result and the writeback
    task automatic run_op(input fu_info_t u, input logic [63:0] exp);
        int cycles;
        @(negedge clk);
        uop = u;
        vld = 1'b1;
        @(negedge clk);
        vld = 1'b0;
        check("o_willwrite_vld", 64'(ww_vld), 64'd1);
        check("o_willwrite_rd_idx", 64'(ww_rd), 64'(u.iprd_idx));
        check("o_willwrite_data", ww_data, exp);
        cycles = 1;
        wait_finished(cycles);
        if (fu_finished) begin
            check("issue to o_fu_finished cycles", 64'(cycles), 64'd2);
            check("o_comwb_info.result", comwb.result, exp);
            check("o_comwb_info.iprd_idx", 64'(comwb.iprd_idx), 64'(u.iprd_idx));
            check("o_comwb_info.rob_idx", 64'(comwb.rob_idx), 64'(u.rob_idx));
            check("o_comwb_info.rd_wen", 64'(comwb.rd_wen), 64'(u.rd_wen));
        end
    endtask

    // back-to-back issue where the second op may read the first one's result
    task automatic issue_pair(input fu_info_t first, input logic [63:0] exp_first,
                              input fu_info_t second, input logic [63:0] exp_second);
        int cycles;
        @(negedge clk);
        uop = first;
        vld = 1'b1;
        @(negedge clk);
        uop = second;
        check("o_willwrite_data", ww_data, exp_first);
        @(negedge clk);
        vld = 1'b0;
        cycles = 2;
        wait_finished(cycles);
        if (fu_finished) begin
            check("o_comwb_info.result", comwb.result, exp_first);
            check("o_comwb_info.rob_idx", 64'(comwb.rob_idx), 64'(first.rob_idx));
            @(negedge clk);
            check("o_fu_finished", 64'(fu_finished), 64'd1);
            check("o_comwb_info.result", comwb.result, exp_second);
            check("o_comwb_info.rob_idx", 64'(comwb.rob_idx), 64'(second.rob_idx));
        end
    endtask

    task automatic test_reset();
        int errs;
        errs = n_errors;
        check("o_fu_finished", 64'(fu_finished), 64'd0);
        check("o_branchwb_vld", 64'(br_vld), 64'd0);
        check("o_willwrite_vld", 64'(ww_vld), 64'd0);
        check("o_redirect_vld", 64'(redirect_vld), 64'd0);
        check("o_issue_block", 64'(issue_block), 64'd0);
        report_test("reset", errs);
    endtask

    task automatic test_alu();
        int          errs;
        micop_t      op;
        fu_info_t    u;
        logic [63:0] a;
        logic [63:0] b;
        errs = n_errors;
        for (int round = 0; round < 2; round++) begin
            for (int k = 0; k <= int'(uop_auipc); k++) begin
                op = micop_t'(k);
                a  = next_random();
                b  = next_random();
                u  = make_uop(op, a, b, 6'(k + 8));
                run_op(u, ref_result(op, u.pc, u.imm20, a, b));
            end
        end
        report_test("alu", errs);
    endtask

    task automatic test_bypass();
        int          errs;
        fu_info_t    first;
        fu_info_t    second;
        logic [63:0] res_a;
        logic [63:0] c;
        logic [63:0] stale;
        logic [63:0] exp;
        errs = n_errors;
        for (int k = 0; k < 3; k++) begin
            first = make_uop(uop_add, next_random(), next_random(), 6'd20);
            res_a = ref_alu(uop_add, first.srcs[0], first.srcs[1]);
            c     = next_random();
            stale = next_random();
            case (k)
                0: begin
                    second = make_uop(uop_sub, stale, c, 6'd21);
                    second.iprs_idx[0] = 6'd20;
                    exp = ref_alu(uop_sub, res_a, c);
                end
                1: begin
                    second = make_uop(uop_xor, c, stale, 6'd22);
                    second.iprs_idx[1] = 6'd20;
                    exp = ref_alu(uop_xor, c, res_a);
                end
                default: begin
                    // source 1 holds the immediate and must not be replaced
                    second = make_uop(uop_add, c, stale, 6'd23);
                    second.iprs_idx[1] = 6'd20;
                    second.use_imm     = 1'b1;
                    exp = ref_alu(uop_add, c, stale);
                end
            endcase
            issue_pair(first, res_a, second, exp);
        end
        report_test("bypass", errs);
    endtask

    task automatic branch_case(input micop_t op, input int variant, input logic mispredict);
        fu_info_t    u;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] exp_npc;
        logic [5:0]  rd;
        a  = next_random();
        b  = (variant == 0) ? a : next_random();
        rd = (op != uop_jalr) ? 6'd12 : (variant == 0) ? 6'd1 : 6'd0;
        u  = make_uop(op, a, b, rd);
        exp_npc = ref_npc(op, u.pc, a, b, u.imm20);
        u.npc   = mispredict ? (exp_npc ^ 64'h40) : exp_npc;
        run_op(u, u.pc + 64'd4);
        check("o_branchwb_vld", 64'(br_vld), 64'(mispredict));
        if (mispredict) begin
            check("o_branchwb_info.has_mispred", 64'(brwb.has_mispred), 64'd1);
            check("o_branchwb_info.taken", 64'(brwb.taken), 64'(ref_taken(op, a, b)));
            check("o_branchwb_info.target_pc", brwb.target_pc,
                  ref_target(op, u.pc, a, u.imm20));
            check("o_branchwb_info.branch_npc", brwb.branch_npc, exp_npc);
            check("o_branchwb_info.branch_type", 64'(brwb.branch_type),
                  64'(ref_br_type(op, rd)));
            check("o_branchwb_info.rob_idx", 64'(brwb.rob_idx), 64'(u.rob_idx));
            check("o_branchwb_info.ftq_idx", 64'(brwb.ftq_idx), 64'(u.ftq_idx));
            // the next instruction starts four bytes on in the fetch block
            check("o_branchwb_info.fallthru_offset", 64'(brwb.fallthru_offset),
                  64'(OFS_W'(u.ftq_offset + 4)));
            @(negedge clk);
            check("o_redirect_vld", 64'(redirect_vld), 64'd1);
            check("o_redirect_pc", redirect_pc, exp_npc);
            check("o_issue_block", 64'(issue_block), 64'd1);
            wait_unblocked();
        end else begin
            @(negedge clk);
            check("o_redirect_vld", 64'(redirect_vld), 64'd0);
        end
    endtask

    task automatic test_branch();
        int errs;
        errs = n_errors;
        for (int mis = 0; mis < 2; mis++) begin
            for (int k = int'(uop_jal); k <= int'(uop_bgeu); k++) begin
                branch_case(micop_t'(k), 0, mis[0]);
                branch_case(micop_t'(k), 1, mis[0]);
            end
        end
        report_test("branch", errs);
    endtask

    task automatic test_refill();
        int          errs;
        int          guard;
        int          count;
        fu_info_t    u;
        fu_info_t    blocked;
        logic [63:0] exp_npc;
        errs = n_errors;
        u = make_uop(uop_jal, 64'd0, 64'd0, 6'd3);
        exp_npc = ref_npc(uop_jal, u.pc, 64'd0, 64'd0, u.imm20);
        u.npc   = exp_npc ^ 64'h80;
        run_op(u, u.pc + 64'd4);
        check("o_branchwb_vld", 64'(br_vld), 64'd1);
        guard = 0;
        while (!redirect_vld && guard < TIMEOUT) begin
            @(negedge clk);
            guard++;
        end
        if (!redirect_vld) begin
            report_timeout("no o_redirect_vld after a mispredict");
        end else begin
            check("o_redirect_pc", redirect_pc, exp_npc);
            // keep offering a micro-op for as long as the block holds
            blocked = make_uop(uop_add, next_random(), next_random(), 6'd4);
            count = 0;
            while (issue_block && count < TIMEOUT) begin
                count++;
                uop = blocked;
                vld = 1'b1;
                @(negedge clk);
                check("o_fu_finished", 64'(fu_finished), 64'd0);
            end
            vld = 1'b0;
            check("o_issue_block cycles", 64'(count), 64'(PENALTY + 1));
            repeat (2) begin
                @(negedge clk);
                check("o_fu_finished", 64'(fu_finished), 64'd0);
            end
            u = make_uop(uop_or, next_random(), next_random(), 6'd5);
            run_op(u, ref_alu(uop_or, u.srcs[0], u.srcs[1]));
        end
        report_test("refill", errs);
    endtask

    task automatic test_stall();
        int          errs;
        int          cycles;
        fu_info_t    first;
        fu_info_t    second;
        logic [63:0] exp_a;
        logic [63:0] exp_b;
        errs   = n_errors;
        first  = make_uop(uop_add, next_random(), next_random(), 6'd30);
        second = make_uop(uop_and, next_random(), next_random(), 6'd31);
        exp_a  = ref_alu(uop_add, first.srcs[0], first.srcs[1]);
        exp_b  = ref_alu(uop_and, second.srcs[0], second.srcs[1]);
        @(negedge clk);
        uop = first;
        vld = 1'b1;
        // second op waits at the input while the stall holds
        @(negedge clk);
        uop   = second;
        stall = 1'b1;
        for (int k = 0; k < 4; k++) begin
            @(negedge clk);
            check("o_fu_finished", 64'(fu_finished), 64'd0);
            check("o_fu_stall", 64'(fu_stall), 64'd1);
            check("o_willwrite_data", ww_data, exp_a);
        end
        stall = 1'b0;
        @(negedge clk);
        vld = 1'b0;
        check("o_fu_stall", 64'(fu_stall), 64'd0);
        cycles = 0;
        wait_finished(cycles);
        if (fu_finished) begin
            check("o_comwb_info.result", comwb.result, exp_a);
            @(negedge clk);
            check("o_fu_finished", 64'(fu_finished), 64'd1);
            check("o_comwb_info.result", comwb.result, exp_b);
        end
        report_test("stall", errs);
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        vld       = 1'b0;
        uop       = '0;
        stall     = 1'b0;
        n_checks  = 0;
        n_errors  = 0;
        rnd_state = 64'd53;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        test_reset();
        test_alu();
        test_bypass();
        test_branch();
        test_refill();
        test_stall();

        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+testbench
rtl/exu_pkg.sv
rtl/operand_bypass.sv
rtl/alu_bru.sv
rtl/redirect_fsm.sv
rtl/penalty_timer.sv
rtl/exu_top.sv
testbench/tb_exu_top.sv

// File: Makefile
# Verilator build and run of the execute cluster testbench

VERILATOR ?= verilator
TOP       ?= tb_exu_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary --timing

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
